// ==== Makefile ====
# Verilator lint and simulation of the ICB 2-to-1 bus merge

VERILATOR ?= verilator
TOP       ?= tb_icb_bus_2to1
RTL_TOP   ?= icb_bus_2to1
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
icb_pkg.sv
icb_fifo.sv
icb_rr_arbiter.sv
icb_rsp_router.sv
icb_bus_2to1.sv
icb_bus_2to1_properties.sv
tb_icb_bus_2to1.sv

// ==== icb_bus_2to1.sv ====
/*
 * ICB 2-to-1 bus merge
 * round-robin arbitration of two requesters onto one memory
 * port, with command and response buffering and in-order
 * routing of responses back to the issuing requester
 */
module icb_bus_2to1 (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  // requester side
  input  logic [icb_pkg::ICB_REQ_NUM-1:0] i_req_cmd_valid,
  output logic [icb_pkg::ICB_REQ_NUM-1:0] o_req_cmd_ready,
  input  icb_pkg::icb_cmd_t               i_req_cmd [icb_pkg::ICB_REQ_NUM],
  output logic [icb_pkg::ICB_REQ_NUM-1:0] o_req_rsp_valid,
  input  logic [icb_pkg::ICB_REQ_NUM-1:0] i_req_rsp_ready,
  output icb_pkg::icb_rsp_t               o_req_rsp,
  // memory side
  output logic                            o_icb_cmd_valid,
  input  logic                            i_icb_cmd_ready,
  output icb_pkg::icb_cmd_t               o_icb_cmd,
  input  logic                            i_icb_rsp_valid,
  output logic                            o_icb_rsp_ready,
  input  icb_pkg::icb_rsp_t               i_icb_rsp
);

  logic              arbt_cmd_valid;
  logic              arbt_cmd_ready;
  icb_pkg::icb_cmd_t arbt_cmd;
  logic              outs_push;
  icb_pkg::req_id_t  outs_push_id;
  logic              outs_full;
  logic              buf_rsp_valid;
  logic              buf_rsp_ready;
  icb_pkg::icb_rsp_t buf_rsp;

  icb_rr_arbiter u_icb_arbt (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req_valid (i_req_cmd_valid),
    .o_req_ready (o_req_cmd_ready),
    .i_req_cmd   (i_req_cmd),
    .o_out_valid (arbt_cmd_valid),
    .i_out_ready (arbt_cmd_ready),
    .o_out_cmd   (arbt_cmd),
    .i_outs_full (outs_full),
    .o_push      (outs_push),
    .o_push_id   (outs_push_id)
  );

  icb_fifo #(
    .DEPTH     (icb_pkg::CMD_FIFO_DP),
    .payload_t (icb_pkg::icb_cmd_t)
  ) u_cmd_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (arbt_cmd_valid),
    .o_ready (arbt_cmd_ready),
    .i_data  (arbt_cmd),
    .o_valid (o_icb_cmd_valid),
    .i_ready (i_icb_cmd_ready),
    .o_data  (o_icb_cmd)
  );

  icb_fifo #(
    .DEPTH     (icb_pkg::RSP_FIFO_DP),
    .payload_t (icb_pkg::icb_rsp_t)
  ) u_rsp_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_icb_rsp_valid),
    .o_ready (o_icb_rsp_ready),
    .i_data  (i_icb_rsp),
    .o_valid (buf_rsp_valid),
    .i_ready (buf_rsp_ready),
    .o_data  (buf_rsp)
  );

  icb_rsp_router u_rsp_router (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_push          (outs_push),
    .i_push_id       (outs_push_id),
    .o_outs_full     (outs_full),
    .i_rsp_valid     (buf_rsp_valid),
    .o_rsp_ready     (buf_rsp_ready),
    .i_rsp           (buf_rsp),
    .o_req_rsp_valid (o_req_rsp_valid),
    .i_req_rsp_ready (i_req_rsp_ready),
    .o_req_rsp       (o_req_rsp)
  );

endmodule

// ==== icb_bus_2to1_properties.sv ====
/*
 * ICB bus merge assertions
 * handshake stability, reset behavior and response routing
 * rules, bound to the bus merge top level
 */
module icb_bus_2to1_properties (
  input logic                            i_clk,
  input logic                            i_rst_n,
  input logic                            o_icb_cmd_valid,
  input logic                            i_icb_cmd_ready,
  input icb_pkg::icb_cmd_t               o_icb_cmd,
  input logic                            i_icb_rsp_valid,
  input logic                            o_icb_rsp_ready,
  input icb_pkg::icb_rsp_t               i_icb_rsp,
  input logic [icb_pkg::ICB_REQ_NUM-1:0] o_req_rsp_valid,
  input logic [icb_pkg::ICB_REQ_NUM-1:0] i_req_rsp_ready,
  input icb_pkg::icb_rsp_t               o_req_rsp
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned outs_cnt;   // memory-side commands still waiting for a response

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      outs_cnt <= 0;
    end else begin
      outs_cnt <= outs_cnt + 32'(o_icb_cmd_valid & i_icb_cmd_ready)
                - 32'(i_icb_rsp_valid & o_icb_rsp_ready);
    end
  end

  cmd_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_icb_cmd_valid && !i_icb_cmd_ready |=> o_icb_cmd_valid && $stable(o_icb_cmd))
    else $error("memory-side command dropped or changed while waiting");

  mem_rsp_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_icb_rsp_valid && !o_icb_rsp_ready |=> i_icb_rsp_valid && $stable(i_icb_rsp))
    else $error("memory-side response dropped or changed while waiting");

  req_rsp_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_req_rsp_valid & ~i_req_rsp_ready) != '0
      |=> ($past(o_req_rsp_valid & ~i_req_rsp_ready) & ~o_req_rsp_valid) == '0
          && $stable(o_req_rsp))
    else $error("requester response dropped or changed while waiting");

  rsp_low_in_reset: assert property (@(posedge i_clk)
    !i_rst_n |-> o_req_rsp_valid == '0)
    else $error("response valid high during reset");

  rsp_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(o_req_rsp_valid))
    else $error("both requester response valids high");

  no_stray_rsp: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_icb_rsp_valid |-> outs_cnt != 0)
    else $error("memory response with nothing outstanding");

endmodule

bind icb_bus_2to1 icb_bus_2to1_properties props_inst (
  .i_clk           (i_clk),
  .i_rst_n         (i_rst_n),
  .o_icb_cmd_valid (o_icb_cmd_valid),
  .i_icb_cmd_ready (i_icb_cmd_ready),
  .o_icb_cmd       (o_icb_cmd),
  .i_icb_rsp_valid (i_icb_rsp_valid),
  .o_icb_rsp_ready (o_icb_rsp_ready),
  .i_icb_rsp       (i_icb_rsp),
  .o_req_rsp_valid (o_req_rsp_valid),
  .i_req_rsp_ready (i_req_rsp_ready),
  .o_req_rsp       (o_req_rsp)
);

// ==== icb_fifo.sv ====
/*
 * ICB channel buffer
 * registered circular FIFO with valid/ready on both sides,
 * payload type set per instance (command or response)
 */
module icb_fifo #(
  parameter int  DEPTH     = 2,
  parameter type payload_t = logic
) (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_valid,
  output logic     o_ready,
  input  payload_t i_data,
  output logic     o_valid,
  input  logic     i_ready,
  output payload_t o_data
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  payload_t mem [DEPTH];
  ptr_t     wr_ptr;
  ptr_t     rd_ptr;
  cnt_t     cnt;
  cnt_t     cnt_nxt;
  logic     rdy_q;
  logic     push;
  logic     pop;

  function automatic ptr_t ptr_inc(input ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign push    = i_valid & rdy_q;
  assign pop     = o_valid & i_ready;
  assign cnt_nxt = cnt + cnt_t'(push) - cnt_t'(pop);

  assign o_ready = rdy_q;           // registered, low through reset
  assign o_valid = (cnt != '0);
  assign o_data  = mem[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
      rdy_q  <= 1'b0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop)  rd_ptr <= ptr_inc(rd_ptr);
      cnt   <= cnt_nxt;
      rdy_q <= (cnt_nxt != cnt_t'(DEPTH));  // drop once full
    end
  end

endmodule

// ==== icb_pkg.sv ====
/*
 * ICB bus merge shared definitions
 * bus widths, buffer depths, the outstanding limit and the
 * packed command and response payloads used on every channel
 */
package icb_pkg;

  // memory port widths
  localparam int ICB_AW = 16;
  localparam int ICB_DW = 64;
  localparam int ICB_MW = ICB_DW / 8;   // one mask bit per byte

  localparam int ICB_REQ_NUM = 2;

  // buffering
  localparam int CMD_FIFO_DP = 2;
  localparam int RSP_FIFO_DP = 2;
  localparam int OUTS_DP     = 4;       // commands in flight before responses

  // command channel payload
  typedef struct packed {
    logic              read;
    logic [ICB_AW-1:0] addr;
    logic [ICB_DW-1:0] wdata;
    logic [ICB_MW-1:0] wmask;
    logic [2:0]        size;   // log2 of transfer bytes
  } icb_cmd_t;

  // response channel payload
  typedef struct packed {
    logic              err;
    logic [ICB_DW-1:0] rdata;
  } icb_rsp_t;

  // requester index carried with each issued command
  typedef logic [$clog2(ICB_REQ_NUM)-1:0] req_id_t;

endpackage

// ==== icb_rr_arbiter.sv ====
/*
 * ICB round-robin arbiter
 * picks one of two command requesters, alternating when both
 * are valid, muxes the granted command onto one channel and
 * reports each accepted grant to the response router
 */
module icb_rr_arbiter (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic [icb_pkg::ICB_REQ_NUM-1:0]     i_req_valid,
  output logic [icb_pkg::ICB_REQ_NUM-1:0]     o_req_ready,
  input  icb_pkg::icb_cmd_t                   i_req_cmd [icb_pkg::ICB_REQ_NUM],
  output logic                                o_out_valid,
  input  logic                                i_out_ready,
  output icb_pkg::icb_cmd_t                   o_out_cmd,
  input  logic                                i_outs_full,
  output logic                                o_push,
  output icb_pkg::req_id_t                    o_push_id
);

  icb_pkg::req_id_t last_q;      // requester granted last
  icb_pkg::req_id_t lock_id_q;
  logic             lock_q;      // offered but not yet taken
  icb_pkg::req_id_t gnt_id;

  always_comb begin
    if (lock_q) begin
      gnt_id = lock_id_q;                       // keep a pending grant
    end else if (&i_req_valid) begin
      gnt_id = ~last_q;                         // both valid, take turns
    end else begin
      gnt_id = icb_pkg::req_id_t'(i_req_valid[1]);
    end
  end

  assign o_out_valid = i_req_valid[gnt_id] & ~i_outs_full;
  assign o_out_cmd   = i_req_cmd[gnt_id];
  assign o_push      = o_out_valid & i_out_ready;
  assign o_push_id   = gnt_id;

  always_comb begin
    for (int n = 0; n < icb_pkg::ICB_REQ_NUM; n++) begin
      o_req_ready[n] = i_req_valid[n] & (gnt_id == icb_pkg::req_id_t'(n))
                     & i_out_ready & ~i_outs_full;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      last_q    <= icb_pkg::req_id_t'(1);  // so requester 0 wins first
      lock_q    <= 1'b0;
      lock_id_q <= '0;
    end else begin
      if (o_push) begin
        last_q <= gnt_id;
      end
      lock_q    <= o_out_valid & ~i_out_ready;
      lock_id_q <= gnt_id;
    end
  end

endmodule

// ==== icb_rsp_router.sv ====
/*
 * ICB response router
 * queues the requester ID of every issued command and steers
 * each buffered response to the requester at the queue head,
 * flags when the outstanding limit is reached
 */
module icb_rsp_router (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  input  logic                            i_push,
  input  icb_pkg::req_id_t                i_push_id,
  output logic                            o_outs_full,
  input  logic                            i_rsp_valid,
  output logic                            o_rsp_ready,
  input  icb_pkg::icb_rsp_t               i_rsp,
  output logic [icb_pkg::ICB_REQ_NUM-1:0] o_req_rsp_valid,
  input  logic [icb_pkg::ICB_REQ_NUM-1:0] i_req_rsp_ready,
  output icb_pkg::icb_rsp_t               o_req_rsp
);

  typedef logic [$clog2(icb_pkg::OUTS_DP)-1:0]   optr_t;
  typedef logic [$clog2(icb_pkg::OUTS_DP+1)-1:0] ocnt_t;

  icb_pkg::req_id_t id_mem [icb_pkg::OUTS_DP];
  optr_t            wr_ptr;
  optr_t            rd_ptr;
  ocnt_t            cnt;
  logic             not_empty;
  icb_pkg::req_id_t head_id;
  logic             pop;

  function automatic optr_t optr_inc(input optr_t p);
    return (p == optr_t'(icb_pkg::OUTS_DP - 1)) ? '0 : p + optr_t'(1);
  endfunction

  assign not_empty   = (cnt != '0);
  assign head_id     = id_mem[rd_ptr];
  assign o_outs_full = (cnt == ocnt_t'(icb_pkg::OUTS_DP));
  assign o_req_rsp   = i_rsp;   // payload shared, valids select the owner
  assign o_rsp_ready = not_empty & i_req_rsp_ready[head_id];
  assign pop         = i_rsp_valid & o_rsp_ready;

  always_comb begin
    for (int n = 0; n < icb_pkg::ICB_REQ_NUM; n++) begin
      o_req_rsp_valid[n] = i_rsp_valid & not_empty
                         & (head_id == icb_pkg::req_id_t'(n));
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) id_mem[wr_ptr] <= i_push_id;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (i_push) wr_ptr <= optr_inc(wr_ptr);
      if (pop)    rd_ptr <= optr_inc(rd_ptr);
      cnt <= cnt + ocnt_t'(i_push) - ocnt_t'(pop);
    end
  end

endmodule

// ==== tb_icb_bus_2to1.sv ====
/*
 * ICB bus merge testbench
 * two random requesters, a memory-side responder and a reference
 * model covering reset, order, fairness, routing and the
 * outstanding limit
 */
module tb_icb_bus_2to1;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_NS     = 40;
  localparam int N_OUTS     = 8;    // per requester, outstanding phase
  localparam int N_FAIR     = 20;
  localparam int N_RAND     = 200;
  localparam int TOTAL_CMDS = 2 * (N_OUTS + N_FAIR + N_RAND);

  logic                            clk = 1'b0;
  logic                            rst_n;
  logic [icb_pkg::ICB_REQ_NUM-1:0] req_valid;
  logic [icb_pkg::ICB_REQ_NUM-1:0] req_cmd_ready;
  icb_pkg::icb_cmd_t               req_cmd [icb_pkg::ICB_REQ_NUM];
  logic [icb_pkg::ICB_REQ_NUM-1:0] req_rsp_valid;
  logic [icb_pkg::ICB_REQ_NUM-1:0] req_rsp_ready;
  icb_pkg::icb_rsp_t               req_rsp;
  logic                            icb_cmd_valid;
  logic                            icb_cmd_ready;
  icb_pkg::icb_cmd_t               icb_cmd;
  logic                            icb_rsp_valid;
  logic                            icb_rsp_ready;
  icb_pkg::icb_rsp_t               icb_rsp;

  // reference model state
  icb_pkg::icb_cmd_t exp_cmd [2][$];
  icb_pkg::icb_rsp_t exp_rsp [2][$];
  icb_pkg::icb_rsp_t mem_rsp_q [$];
  int          sent [2];
  int          target [2];
  logic        req_took [2];
  logic        mem_rsp_took;
  int          hs_count;
  logic        rnd;       // random timing on all sides
  logic        rsp_en;    // memory side answers
  logic        fair_chk;
  logic        have_last;
  logic        last_id;
  logic [31:0] rng = 32'hc6ac_abd9;

  icb_bus_2to1 icb_bus_2to1_inst (
    .i_clk           (clk),
    .i_rst_n         (rst_n),
    .i_req_cmd_valid (req_valid),
    .o_req_cmd_ready (req_cmd_ready),
    .i_req_cmd       (req_cmd),
    .o_req_rsp_valid (req_rsp_valid),
    .i_req_rsp_ready (req_rsp_ready),
    .o_req_rsp       (req_rsp),
    .o_icb_cmd_valid (icb_cmd_valid),
    .i_icb_cmd_ready (icb_cmd_ready),
    .o_icb_cmd       (icb_cmd),
    .i_icb_rsp_valid (icb_rsp_valid),
    .o_icb_rsp_ready (icb_rsp_ready),
    .i_icb_rsp       (icb_rsp)
  );

  always #(CLK_NS / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check_eq(input string name, input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("Finished with errors");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "run aborted");
  endtask

  // bookkeeping at the falling edge, where all signals are settled
  task automatic sample_bus();
    icb_pkg::icb_cmd_t c;
    icb_pkg::icb_rsp_t r;
    int                id;
    for (int n = 0; n < 2; n++) begin
      req_took[n] = req_valid[n] & req_cmd_ready[n];
      if (req_took[n]) begin
        exp_cmd[n].push_back(req_cmd[n]);
        hs_count++;
      end
    end
    if (icb_cmd_valid && icb_cmd_ready) begin
      c  = icb_cmd;
      id = int'(c.addr[15]);   // requester tag
      if (exp_cmd[id].size() == 0) abort_run("memory-side command that no requester issued");
      check_eq("cmd_order", 128'(exp_cmd[id][0]), 128'(c));
      void'(exp_cmd[id].pop_front());
      if (fair_chk && have_last) check_eq("fairness", 128'(!last_id), 128'(id[0]));
      last_id   = id[0];
      have_last = 1'b1;
      r.err     = c.read & c.addr[0];
      r.rdata   = {4{c.addr}} ^ 64'h5a5a_5a5a_5a5a_5a5a;
      exp_rsp[id].push_back(r);
      mem_rsp_q.push_back(r);
    end
    mem_rsp_took = icb_rsp_valid & icb_rsp_ready;
    for (int n = 0; n < 2; n++) begin
      if (req_rsp_valid[n] && req_rsp_ready[n]) begin
        if (exp_rsp[n].size() == 0) abort_run("response delivered to a requester with none due");
        check_eq("rsp_route", 128'(exp_rsp[n][0]), 128'(req_rsp));
        void'(exp_rsp[n].pop_front());
      end
    end
  endtask

  task automatic drive_bus();
    for (int n = 0; n < 2; n++) begin
      rng = xorshift32(rng);
      if (req_took[n]) req_valid[n] = 1'b0;
      if (!req_valid[n] && sent[n] < target[n] && (!rnd || rng[0])) begin
        req_cmd[n].read  = rng[1];
        req_cmd[n].addr  = {1'(n), 15'(sent[n])};
        req_cmd[n].wdata = {rng, ~rng};
        req_cmd[n].wmask = rng[15:8];
        req_cmd[n].size  = 3'd3;
        req_valid[n]     = 1'b1;
        sent[n]++;
      end
      req_rsp_ready[n] = !rnd || rng[2];
    end
    rng           = xorshift32(rng);
    icb_cmd_ready = !rnd || rng[0] || rng[1];
    if (mem_rsp_took) icb_rsp_valid = 1'b0;
    if (!icb_rsp_valid && rsp_en && mem_rsp_q.size() != 0 && (!rnd || rng[2])) begin
      icb_rsp       = mem_rsp_q.pop_front();
      icb_rsp_valid = 1'b1;
    end
  endtask

  function automatic logic drained();
    return sent[0] == target[0] && sent[1] == target[1] && req_valid == '0
        && exp_cmd[0].size() == 0 && exp_cmd[1].size() == 0
        && exp_rsp[0].size() == 0 && exp_rsp[1].size() == 0
        && mem_rsp_q.size() == 0 && !icb_rsp_valid;
  endfunction

  task automatic wait_drained();
    do @(negedge clk); while (!drained());
  endtask

  task automatic run_cycles();
    forever begin
      @(negedge clk);
      sample_bus();
      @(posedge clk);
      #2;
      drive_bus();
    end
  endtask

  initial begin
    rst_n         = 1'b0;
    req_valid     = '0;
    req_rsp_ready = '0;
    req_cmd[0]    = '0;
    req_cmd[1]    = '0;
    icb_cmd_ready = 1'b0;
    icb_rsp_valid = 1'b0;
    icb_rsp       = '0;
    sent          = '{0, 0};
    target        = '{0, 0};
    req_took      = '{1'b0, 1'b0};
    mem_rsp_took  = 1'b0;
    hs_count      = 0;
    rnd           = 1'b0;
    rsp_en        = 1'b0;
    fair_chk      = 1'b0;
    have_last     = 1'b0;
    last_id       = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_eq("reset_cmd_valid", 128'(0), 128'(icb_cmd_valid));
      check_eq("reset_rsp_valid", 128'(0), 128'(req_rsp_valid));
    end
    @(posedge clk);
    #2 rst_n = 1'b1;
    @(posedge clk);   // first clock edge out of reset
    @(negedge clk);
    check_eq("post_reset_cmd_valid", 128'(0), 128'(icb_cmd_valid));
    check_eq("post_reset_rsp_valid", 128'(0), 128'(req_rsp_valid));
    fork
      run_cycles();
    join_none

    // memory holds back responses, only OUTS_DP commands get in
    target = '{N_OUTS, N_OUTS};
    repeat (30) @(negedge clk);
    check_eq("outs_limit", 128'(icb_pkg::OUTS_DP), 128'(hs_count));
    rsp_en = 1'b1;
    wait_drained();

    // both requesters busy, memory always ready
    fair_chk  = 1'b1;
    have_last = 1'b0;
    target    = '{N_OUTS + N_FAIR, N_OUTS + N_FAIR};
    wait_drained();
    fair_chk = 1'b0;

    rnd    = 1'b1;
    target = '{N_OUTS + N_FAIR + N_RAND, N_OUTS + N_FAIR + N_RAND};
    wait_drained();
    repeat (4) @(negedge clk);
    check_eq("idle_cmd_valid", 128'(0), 128'(icb_cmd_valid));
    check_eq("idle_rsp_valid", 128'(0), 128'(req_rsp_valid));
    $display("Finished with no errors");
    $finish;
  end

  // watchdog sized from the total command count
  initial begin
    repeat (2 * TOTAL_CMDS * 20) @(posedge clk);
    abort_run("timeout: traffic did not drain in time");
  end

endmodule
